// ==== verilog.f ====
hdl/div_pkg.sv
hdl/div_cmd_decode.sv
hdl/div_nonrestore_core.sv
hdl/div_result_fix.sv
hdl/div_unit_top.sv
verif/div_unit_props.sv
verif/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the divide unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module div_unit_tb -o div_unit_sim \
	&& ./obj_dir/div_unit_sim | tee /dev/stderr | grep -qx "all tests passed" \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }

// ==== verif/div_unit_tb.sv ====
// Divide unit testbench running random and directed divides against a 64-bit model
`default_nettype none

module div_unit_tb;

	localparam int clk_period = 4;
	localparam int num_normal = 200;
	localparam int num_offset = 100;
	// Each divide counts twice, once for the run and once for its read
	localparam int num_ops    = 2 * (num_normal + num_offset + 16);
	localparam int busy_limit = 40;

	logic                          sys_clk;
	logic                          resetl;
	div_pkg::div_cmd_t             cmd;
	logic                          busy;
	logic [div_pkg::div_width-1:0] quotient;
	logic [div_pkg::div_width-1:0] rd_data;
	logic                          rd_data_en;

	// Model and stimulus state
	logic [31:0]       rng;
	logic              offset_mode;
	logic [31:0]       last_rem;
	logic [31:0]       src;
	logic [31:0]       dst;
	logic [63:0]       model_out;
	int                run_cycles;
	div_pkg::div_cmd_t extra;

	// Bookkeeping
	int test_errors;
	int check_fails;
	int tests_run;
	int tests_failed;

	div_unit_top i_div_unit_top (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.cmd        (cmd),
		.busy       (busy),
		.quotient   (quotient),
		.rd_data    (rd_data),
		.rd_data_en (rd_data_en)
	);

	always #(clk_period / 2) sys_clk = ~sys_clk;

	// 32-bit xorshift step
	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Expected quotient in the upper word, remainder in the lower
	function automatic logic [63:0] divide_model(input logic [31:0] s, input logic [31:0] d,
			input logic fixed);
		logic [63:0] num;
		logic [63:0] q;
		logic [63:0] r;
		// 16.16 mode scales the dividend by 65536
		num = fixed ? {16'h0000, d, 16'h0000} : {32'h0000_0000, d};
		q = num / {32'h0000_0000, s};
		r = num % {32'h0000_0000, s};
		return {q[31:0], r[31:0]};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("error %s: expected %h, actual %h", name, expected, actual);
		test_errors++;
		check_fails++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d checks failed", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// One-cycle command strobe
	task automatic issue(input div_pkg::div_op_e op, input logic [31:0] s, input logic [31:0] d);
		div_pkg::div_cmd_t c;
		c.valid = 1'b1;
		c.op = op;
		c.src = s;
		c.dst = d;
		@(posedge sys_clk);
		cmd <= c;
		@(posedge sys_clk);
		cmd <= '0;
	endtask

	task automatic random_operands(input logic fit_upper, output logic [31:0] s,
			output logic [31:0] d);
		logic [31:0] folded;
		rng = next_random(rng);
		s = rng;
		rng = next_random(rng);
		// Random shift spreads divisor magnitudes
		s = s >> rng[4:0];
		if (s == 32'd0)
			s = 32'd1;
		rng = next_random(rng);
		d = rng;
		// Fixed-point quotient only fits while the upper dividend half is below the divisor
		if (fit_upper && ({16'h0000, d[31:16]} >= s)) begin
			folded = {16'h0000, d[31:16]} % s;
			d[31:16] = folded[15:0];
		end
	endtask

	// Count busy cycles at the falling edge, optionally injecting a command mid-run
	task automatic wait_busy(input string name, input int inject_at,
			input div_pkg::div_cmd_t inject, output int cycles);
		cycles = 0;
		@(negedge sys_clk);
		while (busy && cycles < busy_limit) begin
			cycles++;
			@(posedge sys_clk);
			if (cycles == inject_at) begin
				cmd <= inject;
			end else begin
				cmd <= '0;
			end
			@(negedge sys_clk);
		end
		if (busy) begin
			$display("%s: busy still high after %0d cycles", name, busy_limit);
			test_errors++;
			check_fails++;
		end
	endtask

	// Data and enable show up the cycle after the strobe, for one cycle
	task automatic read_check(input string name, input logic [31:0] expected);
		issue(div_pkg::op_rem_rd, 32'd0, 32'd0);
		@(negedge sys_clk);
		if (rd_data_en !== 1'b1)
			report_mismatch({name, " rd_data_en"}, 32'd1, {31'd0, rd_data_en});
		if (rd_data !== expected)
			report_mismatch({name, " remainder"}, expected, rd_data);
		@(negedge sys_clk);
		if (rd_data_en !== 1'b0)
			report_mismatch({name, " rd_data_en pulse"}, 32'd0, {31'd0, rd_data_en});
	endtask

	task automatic divide_check(input string name, input logic [31:0] s, input logic [31:0] d,
			input int inject_at, input div_pkg::div_cmd_t inject);
		logic [63:0] expected;
		int cycles;
		expected = divide_model(s, d, offset_mode);
		issue(div_pkg::op_divide, s, d);
		wait_busy(name, inject_at, inject, cycles);
		if (cycles != div_pkg::div_steps)
			report_mismatch({name, " busy cycles"}, div_pkg::div_steps, cycles);
		if (quotient !== expected[63:32])
			report_mismatch({name, " quotient"}, expected[63:32], quotient);
		read_check(name, expected[31:0]);
		last_rem = expected[31:0];
	endtask

	initial begin
		sys_clk = 1'b0;
		resetl <= 1'b0;
		cmd <= '0;
		rng = 32'd36989;
		offset_mode = 1'b0;
		last_rem = 32'd0;
		extra = '0;
		test_errors = 0;
		check_fails = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge sys_clk);
		resetl <= 1'b1;

		@(negedge sys_clk);
		if (busy !== 1'b0)
			report_mismatch("reset busy", 32'd0, {31'd0, busy});
		if (rd_data_en !== 1'b0)
			report_mismatch("reset rd_data_en", 32'd0, {31'd0, rd_data_en});
		if (quotient !== 32'd0)
			report_mismatch("reset quotient", 32'd0, quotient);
		finish_test("reset");

		for (int i = 0; i < num_normal; i++) begin
			random_operands(1'b0, src, dst);
			divide_check($sformatf("normal %0d", i), src, dst, 0, '0);
		end
		finish_test("random normal");

		issue(div_pkg::op_ctrl_wr, 32'd1, 32'd0);
		offset_mode = 1'b1;
		for (int i = 0; i < num_offset; i++) begin
			random_operands(1'b1, src, dst);
			divide_check($sformatf("offset %0d", i), src, dst, 0, '0);
		end
		// Clearing bit 0 returns to integer divides
		issue(div_pkg::op_ctrl_wr, 32'd0, 32'd0);
		offset_mode = 1'b0;
		divide_check("offset cleared", 32'd7, 32'd100, 0, '0);
		finish_test("offset mode");

		divide_check("dst below src", 32'd9, 32'd5, 0, '0);
		divide_check("dst equals src", 32'h0012_d687, 32'h0012_d687, 0, '0);
		divide_check("divisor one", 32'd1, 32'hdead_beef, 0, '0);
		divide_check("all ones", 32'hffff_ffff, 32'hffff_ffff, 0, '0);
		divide_check("all ones dividend", 32'd3, 32'hffff_ffff, 0, '0);
		divide_check("all ones divisor", 32'hffff_ffff, 32'd1, 0, '0);
		finish_test("edge operands");

		// Second divide lands in the fifth busy cycle and has to vanish
		extra.valid = 1'b1;
		extra.op = div_pkg::op_divide;
		extra.src = 32'd3;
		extra.dst = 32'd1000;
		divide_check("dropped", 32'd7, 32'd123456, 4, extra);
		finish_test("dropped divide");

		// Overlapping read sees the previous remainder
		divide_check("read busy first", 32'd13, 32'd1000, 0, '0);
		issue(div_pkg::op_divide, 32'd17, 32'd5000);
		read_check("read busy overlap", last_rem);
		if (busy !== 1'b1) begin
			$display("read busy overlap: core went idle before the read finished");
			test_errors++;
			check_fails++;
		end
		wait_busy("read busy second", 0, '0, run_cycles);
		model_out = divide_model(32'd17, 32'd5000, 1'b0);
		if (quotient !== model_out[63:32])
			report_mismatch("read busy second quotient", model_out[63:32], quotient);
		read_check("read busy second", model_out[31:0]);
		finish_test("read while busy");

		$display("%0d tests run, %0d failed, %0d checks failed", tests_run, tests_failed,
			check_fails);
		if (check_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Run limit of 20 cycles per operation
	initial begin
		#(num_ops * 20 * clk_period);
		$display("watchdog expired after %0d cycles", num_ops * 20);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/div_unit_props.sv ====
// Divide unit assertions on busy length, start gating and read enable timing
`default_nettype none

module div_unit_props (
	input wire sys_clk,
	input wire resetl,
	input wire busy,
	input wire go,
	input wire done,
	input wire rem_rd,
	input wire rd_data_en
);

	// Core begins a run on the edge after an accepted start
	start_taken: assert property (@(posedge sys_clk) disable iff (!resetl) go |=> busy)
		else $error("core did not go busy after a start");

	// Last busy cycle carries done
	busy_done: assert property (@(posedge sys_clk) disable iff (!resetl)
		$rose(busy) |-> ##(div_pkg::div_steps - 1) (busy && done))
		else $error("done missing on the last busy cycle");

	// Busy drops right after div_steps cycles
	busy_length: assert property (@(posedge sys_clk) disable iff (!resetl)
		$rose(busy) |-> ##(div_pkg::div_steps) !busy)
		else $error("busy longer than div_steps cycles");

	// Read enable follows the strobe by one cycle, never otherwise
	read_enable: assert property (@(posedge sys_clk) disable iff (!resetl) rem_rd |=> rd_data_en)
		else $error("rd_data_en missing after a read strobe");
	stray_enable: assert property (@(posedge sys_clk) disable iff (!resetl)
		!rem_rd |=> !rd_data_en)
		else $error("rd_data_en without a read strobe");

endmodule

bind div_nonrestore_core div_unit_props i_core_props (
	.sys_clk(sys_clk), .resetl(resetl), .busy(busy), .go(start.go), .done(core_out.done),
	.rem_rd(1'b0), .rd_data_en(1'b0)
);

bind div_result_fix div_unit_props i_result_props (
	.sys_clk(sys_clk), .resetl(resetl), .busy(1'b0), .go(1'b0), .done(1'b0),
	.rem_rd(rem_rd), .rd_data_en(rd_data_en)
);

`default_nettype wire

// ==== hdl/div_unit_top.sv ====
// Integer divide unit top level joining command decode, divider core and result stage
`default_nettype none

module div_unit_top (
	input  wire                             sys_clk,
	input  wire                             resetl,
	input  div_pkg::div_cmd_t               cmd,
	output logic                            busy,
	output logic [div_pkg::div_width-1:0]   quotient,
	output logic [div_pkg::div_width-1:0]   rd_data,
	output logic                            rd_data_en
);

	// Decode to core
	div_pkg::div_start_t    start;

	// Decode to result stage
	logic                   rem_rd;

	// Core to result stage
	div_pkg::div_core_out_t core_out;

	div_cmd_decode i_div_cmd_decode (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.cmd     (cmd),
		.busy    (busy),
		.start   (start),
		.rem_rd  (rem_rd)
	);

	div_nonrestore_core i_div_nonrestore_core (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.start    (start),
		.busy     (busy),
		.quotient (quotient),
		.core_out (core_out)
	);

	div_result_fix i_div_result_fix (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.core_out   (core_out),
		.rem_rd     (rem_rd),
		.rd_data    (rd_data),
		.rd_data_en (rd_data_en)
	);

endmodule

`default_nettype wire

// ==== hdl/div_result_fix.sv ====
// Divide result stage fixing the final remainder and serving remainder reads
`default_nettype none

module div_result_fix (
	input  wire                             sys_clk,
	input  wire                             resetl,
	input  div_pkg::div_core_out_t          core_out,
	input  wire                             rem_rd,
	output logic [div_pkg::div_width-1:0]   rd_data,
	output logic                            rd_data_en
);

	// Last completed remainder
	logic [div_pkg::div_width-1:0] rem_q;

	// Corrected remainder
	logic [div_pkg::div_width-1:0] rem_fixed;

	// Negative partial remainder gets the divisor added back
	always_comb begin
		if (core_out.rem_neg) begin
			rem_fixed = core_out.partial_rem + core_out.divisor;
		end else begin
			rem_fixed = core_out.partial_rem;
		end
	end

	// Quotient travels with the result but is read from the core directly
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rem_q <= '0;
		end else if (core_out.done) begin
			rem_q <= rem_fixed;
		end
	end

	// Reads during a run see the previous result
	always_ff @(posedge sys_clk) begin
		if (rem_rd) begin
			rd_data <= rem_q;
		end
	end

	// Enable is one cycle, the clock after the read strobe
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rd_data_en <= 1'b0;
		end else begin
			rd_data_en <= rem_rd;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/div_nonrestore_core.sv ====
// Non-restoring unsigned divider core retiring two quotient bits per clock
`default_nettype none

module div_nonrestore_core (
	input  wire                                 sys_clk,
	input  wire                                 resetl,
	input  div_pkg::div_start_t                 start,
	output logic                                busy,
	output logic [div_pkg::div_width-1:0]       quotient,
	output div_pkg::div_core_out_t              core_out
);

	// Partial remainder, low 32 bits of a 33-bit signed value
	logic [div_pkg::div_width-1:0] dividend_hi;
	// Dividend bits still to be shifted in, MSB first
	logic [div_pkg::div_width-1:0] dividend_lo;
	logic [div_pkg::div_width-1:0] divisor;

	// Sign of the partial remainder after the last step
	logic last_neg;

	// Quotient bits collected so far
	logic [div_pkg::div_width-1:0] quot;

	logic [div_pkg::div_cnt_width-1:0] count;

	// First and second add-or-subtract stage of one clock
	logic [div_pkg::div_width:0] shift1;
	logic [div_pkg::div_width:0] step1;
	logic [div_pkg::div_width:0] shift2;
	logic [div_pkg::div_width:0] step2;
	logic [div_pkg::div_width:0] divisor_ext;
	logic                        neg1;
	logic                        neg2;

	// Next quotient with this clock's two bits appended
	logic [div_pkg::div_width-1:0] quot_next;

	logic last_step;

	// Two chained stages per clock
	always_comb begin
		divisor_ext = {1'b0, divisor};

		// Shift in the next dividend bit
		shift1 = {dividend_hi, dividend_lo[div_pkg::div_width-1]};
		// Subtract after a positive remainder, add after a negative one
		// Result stays within 33 bits, so wrap-around is harmless
		if (last_neg) begin
			step1 = shift1 + divisor_ext;
		end else begin
			step1 = shift1 - divisor_ext;
		end
		neg1 = step1[div_pkg::div_width];

		// Second stage works off the first stage's sign
		shift2 = {step1[div_pkg::div_width-1:0], dividend_lo[div_pkg::div_width-2]};
		if (neg1) begin
			step2 = shift2 + divisor_ext;
		end else begin
			step2 = shift2 - divisor_ext;
		end
		neg2 = step2[div_pkg::div_width];

		// Quotient bit is set when the new remainder is not negative
		quot_next = {quot[div_pkg::div_width-3:0], ~neg1, ~neg2};
	end

	assign last_step = busy && (count == div_pkg::div_last_cnt);

	// Iteration control and quotient
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			busy     <= 1'b0;
			count    <= '0;
			last_neg <= 1'b0;
			quot     <= '0;
		end else if (start.go) begin
			busy     <= 1'b1;
			count    <= '0;
			// First step always subtracts
			last_neg <= 1'b0;
			quot     <= '0;
		end else if (busy) begin
			count    <= count + 1'b1;
			last_neg <= neg2;
			quot     <= quot_next;
			if (last_step) begin
				busy <= 1'b0;
			end
		end
	end

	// Data path registers
	always_ff @(posedge sys_clk) begin
		if (start.go) begin
			divisor <= start.divisor;
			if (start.offset) begin
				// 16.16 mode, dividend is dst shifted up by 16
				dividend_hi <= {16'h0000, start.dividend[31:16]};
				dividend_lo <= {start.dividend[15:0], 16'h0000};
			end else begin
				dividend_hi <= '0;
				dividend_lo <= start.dividend;
			end
		end else if (busy) begin
			dividend_hi <= step2[div_pkg::div_width-1:0];
			dividend_lo <= {dividend_lo[div_pkg::div_width-3:0], 2'b00};
		end
	end

	// Quotient holds after the run until the next start
	assign quotient = quot;

	// Final values are taken from the last step before they register
	always_comb begin
		core_out.done        = last_step;
		core_out.quotient    = quot_next;
		core_out.partial_rem = step2[div_pkg::div_width-1:0];
		core_out.rem_neg     = neg2;
		core_out.divisor     = divisor;
	end

endmodule

`default_nettype wire

// ==== hdl/div_cmd_decode.sv ====
// Divide command decoder holding the fixed-point control bit and gating starts
`default_nettype none

module div_cmd_decode (
	input  wire                     sys_clk,
	input  wire                     resetl,
	input  div_pkg::div_cmd_t       cmd,
	input  wire                     busy,
	output div_pkg::div_start_t     start,
	output logic                    rem_rd
);

	// Divide control register, bit 0 only
	logic offset;

	// Per-opcode strobes
	logic ctrl_wr;
	logic div_req;

	always_comb begin
		ctrl_wr = cmd.valid && (cmd.op == div_pkg::op_ctrl_wr);
		div_req = cmd.valid && (cmd.op == div_pkg::op_divide);
		// Read strobe goes straight to the result stage
		rem_rd = cmd.valid && (cmd.op == div_pkg::op_rem_rd);
	end

	// Control register write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			offset <= 1'b0;
		end else if (ctrl_wr) begin
			offset <= cmd.src[0];
		end
	end

	// Start is combinational so the core loads on the command edge
	always_comb begin
		// A divide while the core runs is dropped
		start.go       = div_req && !busy;
		start.offset   = offset;
		start.divisor  = cmd.src;
		start.dividend = cmd.dst;
	end

endmodule

`default_nettype wire

// ==== hdl/div_pkg.sv ====
// Divide unit package with shared widths, command opcodes and stage structs
`default_nettype none

package div_pkg;

	// Data path width
	localparam int div_width = 32;

	// Two quotient bits retire per clock
	localparam int div_steps = div_width / 2;

	// Iteration counter
	localparam int div_cnt_width = 4;
	localparam logic [div_cnt_width-1:0] div_last_cnt = div_cnt_width'(div_steps - 1);

	// Command opcodes
	typedef enum logic [1:0] {
		op_none    = 2'd0,
		op_ctrl_wr = 2'd1,
		op_divide  = 2'd2,
		op_rem_rd  = 2'd3
	} div_op_e;

	// Command as seen on the unit input, strobed for one cycle
	typedef struct packed {
		logic                 valid;
		div_op_e              op;
		// Divisor, or control data on a control write
		logic [div_width-1:0] src;
		// Dividend
		logic [div_width-1:0] dst;
	} div_cmd_t;

	// Start request from decode into the core
	typedef struct packed {
		logic                 go;
		// 16.16 fixed-point mode
		logic                 offset;
		logic [div_width-1:0] divisor;
		logic [div_width-1:0] dividend;
	} div_start_t;

	// Core result, valid while done is high
	typedef struct packed {
		logic                 done;
		logic [div_width-1:0] quotient;
		// Remainder before the final add-back
		logic [div_width-1:0] partial_rem;
		logic                 rem_neg;
		logic [div_width-1:0] divisor;
	} div_core_out_t;

endpackage

`default_nettype wire
